//--- design/hss_pkg.sv
// Shared types and control-word encodings for the serial lane link controller.
// RTL and testbench refer to everything here by scoped name (hss_pkg::...).
// Layouts: handshake = {phase, version, marker, comma}; idle = {0, 0, 0, comma}.
package hss_pkg;

  // One lane word and its per-byte K-character flags
  typedef logic [31:0] hss_word_t;
  typedef logic [3:0]  hss_kflags_t;
  typedef logic [7:0]  hss_byte_t;

  // K28.5 comma, sent in byte 0 of every handshake and idle word
  localparam hss_byte_t COMMA_K          = 8'hBC;
  // K28.0, repeated four times to form the clock-correction word
  localparam hss_byte_t CLKCOR_K         = 8'h1C;
  // Data byte 1 of a handshake word
  localparam hss_byte_t HS_MARKER        = 8'h5A;
  // Local protocol version, byte 2 of a handshake word
  localparam hss_byte_t PROTOCOL_VERSION = 8'h01;

  // Only byte 0 is a K character in handshake and idle words
  localparam hss_kflags_t BYTE0_KFLAGS  = 4'b0001;
  localparam hss_kflags_t CLKCOR_KFLAGS = 4'b1111;

  localparam hss_word_t CLKCOR_WORD = {4{CLKCOR_K}};
  localparam hss_word_t IDLE_WORD   = {24'h000000, COMMA_K};

  // Receive handshake progress
  typedef enum logic [1:0] {
    HS_SEARCH,
    HS_PHASE1,
    HS_DONE
  } hss_rx_state_t;

  // Build a handshake word with the given phase flag in bit 0 of byte 3
  function automatic hss_word_t make_hs_word(input logic phase);
    make_hs_word = {7'b0000000, phase, PROTOCOL_VERSION, HS_MARKER, COMMA_K};
  endfunction

endpackage

//--- design/hss_tx_control.sv
// Transmit word selection for one serial lane.
// Each cycle one registered word goes out: clock correction in its slot,
// handshake words until the link is up, then user words or idle words.
// User words enter on a tx_vld_i / tx_rdy_o handshake.

`timescale 1ns/100ps

module hss_tx_control #(
  parameter int CLKCOR_INTERVAL = 1000
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Handshake status from the receive side
  input  logic                 handshake_complete_i,
  input  logic                 handshake_phase_i,

  // User transmit port
  input  hss_pkg::hss_word_t   tx_data_i,
  input  hss_pkg::hss_kflags_t tx_charisk_i,
  input  logic                 tx_vld_i,
  output logic                 tx_rdy_o,

  // To the transceiver
  output hss_pkg::hss_word_t   txdata_o,
  output hss_pkg::hss_kflags_t txcharisk_o
);

  //////////////////////////////////////////////////////////////////////
  // Clock-correction slot counter
  //////////////////////////////////////////////////////////////////////

  // At least one bit, even for an interval of 1
  localparam int CC_CNT_W = (CLKCOR_INTERVAL > 1) ? $clog2(CLKCOR_INTERVAL) : 1;

  typedef logic [CC_CNT_W-1:0] cc_cnt_t;

  localparam cc_cnt_t CC_RELOAD = cc_cnt_t'(CLKCOR_INTERVAL - 1);

  cc_cnt_t              cc_cnt_q;
  logic                 cc_slot;

  hss_pkg::hss_word_t   txdata_d;
  hss_pkg::hss_word_t   txdata_q;
  hss_pkg::hss_kflags_t txcharisk_d;
  hss_pkg::hss_kflags_t txcharisk_q;

  // Counter at zero means the coming edge loads the clock-correction word
  assign cc_slot = (cc_cnt_q == '0);

  // Counts down from reset release, one slot every CLKCOR_INTERVAL cycles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cc_cnt_q <= CC_RELOAD;
    end else if (cc_slot) begin
      cc_cnt_q <= CC_RELOAD;
    end else begin
      cc_cnt_q <= cc_cnt_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // User handshake
  //////////////////////////////////////////////////////////////////////

  // Accept only once the link is up and the next word is not the
  // clock-correction word, so an accepted word is never displaced
  assign tx_rdy_o = handshake_complete_i && !cc_slot;

  //////////////////////////////////////////////////////////////////////
  // Output word selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (cc_slot) begin
      // Clock correction wins over everything
      txdata_d    = hss_pkg::CLKCOR_WORD;
      txcharisk_d = hss_pkg::CLKCOR_KFLAGS;
    end else if (!handshake_complete_i) begin
      // Keep handshaking, phase flag follows the receiver
      txdata_d    = hss_pkg::make_hs_word(handshake_phase_i);
      txcharisk_d = hss_pkg::BYTE0_KFLAGS;
    end else if (tx_vld_i) begin
      // tx_rdy_o is high here, so this is an accepted user word
      txdata_d    = tx_data_i;
      txcharisk_d = tx_charisk_i;
    end else begin
      // Nothing to send
      txdata_d    = hss_pkg::IDLE_WORD;
      txcharisk_d = hss_pkg::BYTE0_KFLAGS;
    end
  end

  // Output register; comes out of reset sending phase-0 handshakes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      txdata_q    <= hss_pkg::make_hs_word(1'b0);
      txcharisk_q <= hss_pkg::BYTE0_KFLAGS;
    end else begin
      txdata_q    <= txdata_d;
      txcharisk_q <= txcharisk_d;
    end
  end

  assign txdata_o    = txdata_q;
  assign txcharisk_o = txcharisk_q;

endmodule

//--- design/hss_rx_control.sv
// Receive side of the serial lane link controller.
// Classifies incoming words, counts consecutive valid handshakes, tracks
// the handshake phase and remote version, and passes only user words on.
// rx_vld_o is a one-cycle strobe; the lane cannot be stalled.

`timescale 1ns/100ps

module hss_rx_control #(
  parameter int NUM_HANDSHAKES = 100
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // From the transceiver
  input  hss_pkg::hss_word_t   rxdata_i,
  input  hss_pkg::hss_kflags_t rxcharisk_i,
  input  hss_pkg::hss_kflags_t rxchariscomma_i,
  input  logic [1:0]           rxlossofsync_i,

  // Handshake status
  output logic                 handshake_phase_o,
  output logic                 handshake_complete_o,
  output logic                 version_mismatch_o,

  // User receive port
  output hss_pkg::hss_word_t   rx_data_o,
  output hss_pkg::hss_kflags_t rx_charisk_o,
  output logic                 rx_vld_o
);

  // Wide enough to hold NUM_HANDSHAKES itself
  localparam int HS_CNT_W = $clog2(NUM_HANDSHAKES + 1);

  typedef logic [HS_CNT_W-1:0] hs_cnt_t;

  localparam hs_cnt_t HS_CNT_MAX  = hs_cnt_t'(NUM_HANDSHAKES);
  localparam hs_cnt_t HS_CNT_LAST = hs_cnt_t'(NUM_HANDSHAKES - 1);

  hss_pkg::hss_rx_state_t state_d;
  hss_pkg::hss_rx_state_t state_q;
  hs_cnt_t                hs_cnt_q;

  logic                   is_hs;
  logic                   ver_ok;
  logic                   hs_good;
  logic                   hs_bad;
  logic                   is_clkcor;
  logic                   is_user;
  logic                   sync_lost;
  logic                   hs_reached;

  logic                   mismatch_q;
  logic                   rx_vld_q;
  hss_pkg::hss_word_t     rx_data_q;
  hss_pkg::hss_kflags_t   rx_charisk_q;

  //////////////////////////////////////////////////////////////////////
  // Word classification
  //////////////////////////////////////////////////////////////////////

  // Handshake: comma in byte 0 plus the marker byte
  assign is_hs     = rxchariscomma_i[0] && (rxdata_i[15:8] == hss_pkg::HS_MARKER);
  assign ver_ok    = (rxdata_i[23:16] == hss_pkg::PROTOCOL_VERSION);
  assign hs_good   = is_hs && ver_ok;
  assign hs_bad    = is_hs && !ver_ok;
  assign is_clkcor = (rxcharisk_i == hss_pkg::CLKCOR_KFLAGS) &&
                     (rxdata_i == hss_pkg::CLKCOR_WORD);
  // Byte 0 not a K character
  assign is_user   = !rxcharisk_i[0];
  // Bit 1 set means sync is lost, bit 0 alone is a resync in progress
  assign sync_lost = rxlossofsync_i[1];

  // This good handshake brings the run up to NUM_HANDSHAKES
  assign hs_reached = hs_good && (hs_cnt_q >= HS_CNT_LAST);

  //////////////////////////////////////////////////////////////////////
  // Consecutive handshake counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_cnt_q <= '0;
    end else if (sync_lost) begin
      hs_cnt_q <= '0;
    end else if (hs_good) begin
      // Saturate once the target is reached
      if (hs_cnt_q != HS_CNT_MAX) begin
        hs_cnt_q <= hs_cnt_q + 1'b1;
      end
    end else if (!is_clkcor) begin
      // Clock correction may sit inside a run and does not break it
      hs_cnt_q <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (sync_lost || hs_bad) begin
      // Lane dropped or remote speaks another version, start over
      state_d = hss_pkg::HS_SEARCH;
    end else begin
      case (state_q)
        hss_pkg::HS_SEARCH: if (hs_reached) state_d = hss_pkg::HS_PHASE1;
        // Remote has seen our handshakes too once it sends phase 1
        hss_pkg::HS_PHASE1: if (hs_good && rxdata_i[24]) state_d = hss_pkg::HS_DONE;
        hss_pkg::HS_DONE:   state_d = hss_pkg::HS_DONE;
        default:            state_d = hss_pkg::HS_SEARCH;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= hss_pkg::HS_SEARCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign handshake_phase_o    = (state_q == hss_pkg::HS_PHASE1);
  assign handshake_complete_o = (state_q == hss_pkg::HS_DONE);

  //////////////////////////////////////////////////////////////////////
  // Remote version tracking
  //////////////////////////////////////////////////////////////////////

  // Last handshake seen decides, other words leave it alone
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mismatch_q <= 1'b0;
    end else if (hs_bad) begin
      mismatch_q <= 1'b1;
    end else if (hs_good) begin
      mismatch_q <= 1'b0;
    end
  end

  assign version_mismatch_o = mismatch_q;

  //////////////////////////////////////////////////////////////////////
  // User word filter
  //////////////////////////////////////////////////////////////////////

  // Strobe only for user words on a settled lane with the link up
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_vld_q <= 1'b0;
    end else begin
      rx_vld_q <= (state_q == hss_pkg::HS_DONE) && is_user && (rxlossofsync_i == 2'b00);
    end
  end

  // Payload only follows user words
  always_ff @(posedge clk_i) begin
    if (is_user) begin
      rx_data_q    <= rxdata_i;
      rx_charisk_q <= rxcharisk_i;
    end
  end

  assign rx_data_o    = rx_data_q;
  assign rx_charisk_o = rx_charisk_q;
  assign rx_vld_o     = rx_vld_q;

endmodule

//--- design/hss_link.sv
// Link controller top level for one serial lane.
// Joins the transmit and receive controllers and passes the clock-correction
// interval and handshake count down to them. The lane ports go straight to
// the transceiver; the user ports carry 32-bit words with K flags.

`timescale 1ns/100ps

module hss_link #(
  // Cycles between clock-correction words
  parameter int CLKCOR_INTERVAL = 1000,
  // Consecutive good handshakes before moving to phase 1
  parameter int NUM_HANDSHAKES  = 100
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Link status
  output logic                 handshake_complete_o,
  output logic                 version_mismatch_o,

  // Transceiver receive side
  input  hss_pkg::hss_word_t   rxdata_i,
  input  hss_pkg::hss_kflags_t rxchariscomma_i,
  input  hss_pkg::hss_kflags_t rxcharisk_i,
  input  logic [1:0]           rxlossofsync_i,

  // Transceiver transmit side
  output hss_pkg::hss_word_t   txdata_o,
  output hss_pkg::hss_kflags_t txcharisk_o,

  // User transmit port
  input  hss_pkg::hss_word_t   tx_data_i,
  input  hss_pkg::hss_kflags_t tx_charisk_i,
  input  logic                 tx_vld_i,
  output logic                 tx_rdy_o,

  // User receive port
  output hss_pkg::hss_word_t   rx_data_o,
  output hss_pkg::hss_kflags_t rx_charisk_o,
  output logic                 rx_vld_o
);

  ////////////////////////////////////////////////////////////////////
  // Transmit and receive controllers
  ////////////////////////////////////////////////////////////////////

  // Receiver tells the transmitter which handshake phase to advertise
  logic handshake_phase;

  hss_tx_control #(
    .CLKCOR_INTERVAL (CLKCOR_INTERVAL)
  ) hss_tx_control_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .handshake_complete_i (handshake_complete_o),
    .handshake_phase_i    (handshake_phase),
    .tx_data_i            (tx_data_i),
    .tx_charisk_i         (tx_charisk_i),
    .tx_vld_i             (tx_vld_i),
    .tx_rdy_o             (tx_rdy_o),
    .txdata_o             (txdata_o),
    .txcharisk_o          (txcharisk_o)
  );

  hss_rx_control #(
    .NUM_HANDSHAKES (NUM_HANDSHAKES)
  ) hss_rx_control_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .rxdata_i             (rxdata_i),
    .rxcharisk_i          (rxcharisk_i),
    .rxchariscomma_i      (rxchariscomma_i),
    .rxlossofsync_i       (rxlossofsync_i),
    .handshake_phase_o    (handshake_phase),
    .handshake_complete_o (handshake_complete_o),
    .version_mismatch_o   (version_mismatch_o),
    .rx_data_o            (rx_data_o),
    .rx_charisk_o         (rx_charisk_o),
    .rx_vld_o             (rx_vld_o)
  );

endmodule

//--- tests/hss_link_properties.sv
// Concurrent assertions for the serial lane link controller.
// Bound into every hss_link instance and watches the lane words,
// the user ports and the receive FSM state.

`timescale 1ns/100ps

module hss_link_properties #(
  parameter int CLKCOR_INTERVAL = 1000
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   tx_rdy_i,
  input logic                   handshake_complete_i,
  input logic                   version_mismatch_i,
  input logic                   rx_vld_i,
  input hss_pkg::hss_kflags_t   rxcharisk_i,
  input hss_pkg::hss_word_t     txdata_i,
  input hss_pkg::hss_kflags_t   txcharisk_i,
  input hss_pkg::hss_rx_state_t rx_state_i
);

  // Number of failed assertions so far
  int   fail_cnt = 0;
  int   since_cc_q;
  logic is_cc;

  // Four K28.0 with all flags set make a clock-correction word on the lane
  assign is_cc = (txdata_i == hss_pkg::CLKCOR_WORD) && (txcharisk_i == hss_pkg::CLKCOR_KFLAGS);

  // Cycles since reset release or since the last clock-correction word
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      since_cc_q <= 0;
    end else if (is_cc) begin
      since_cc_q <= 1;
    end else begin
      since_cc_q <= since_cc_q + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Link and reset behavior
  //////////////////////////////////////////////////////////////////////

  rdy_needs_link: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_rdy_i |-> handshake_complete_i)
    else begin
      fail_cnt++;
      $error("tx_rdy_o high while the link is down");
    end

  // Control outputs quiet for the whole reset
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !(tx_rdy_i || rx_vld_i || handshake_complete_i || version_mismatch_i))
    else begin
      fail_cnt++;
      $error("control output high during reset");
    end

  //////////////////////////////////////////////////////////////////////
  // Clock correction and receive filter
  //////////////////////////////////////////////////////////////////////

  // Exactly one word per interval, never early and never missed
  clkcor_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    is_cc == (since_cc_q == CLKCOR_INTERVAL))
    else begin
      fail_cnt++;
      $error("clock-correction word off its period");
    end

  // No user word accepted in the cycle before a clock-correction word
  rdy_low_before_cc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    is_cc |-> !$past(tx_rdy_i))
    else begin
      fail_cnt++;
      $error("tx_rdy_o high just before clock correction");
    end

  // Strobe only for a lane word without K in byte 0 while the link was up
  rx_user_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_vld_i |-> (!$past(rxcharisk_i[0]) && $past(rx_state_i) == hss_pkg::HS_DONE))
    else begin
      fail_cnt++;
      $error("rx_vld_o on a control word or before HS_DONE");
    end

endmodule

bind hss_link hss_link_properties #(
  .CLKCOR_INTERVAL (CLKCOR_INTERVAL)
) props_i (
  .clk_i                (clk_i),
  .rst_n_i              (rst_n_i),
  .tx_rdy_i             (tx_rdy_o),
  .handshake_complete_i (handshake_complete_o),
  .version_mismatch_i   (version_mismatch_o),
  .rx_vld_i             (rx_vld_o),
  .rxcharisk_i          (rxcharisk_i),
  .txdata_i             (txdata_o),
  .txcharisk_i          (txcharisk_o),
  .rx_state_i           (hss_rx_control_i.state_q)
);

//--- tests/hss_link_tb.sv
// Testbench for the serial lane link controller.
// The lane is looped back onto itself; a fault mux can replace the looped
// words with chosen ones, and loss of sync can be raised on its own.
// Random user words run through a scoreboard in arrival order.

`timescale 1ns/100ps

module hss_link_tb;

  localparam int CLKCOR_INTERVAL = 40;
  localparam int NUM_HANDSHAKES  = 8;
  // Longest any single wait may take, in cycles
  localparam int WAIT_LIMIT      = 400;

  logic                 clk;
  logic                 rst_n;
  logic                 handshake_complete;
  logic                 version_mismatch;
  hss_pkg::hss_word_t   rxdata;
  hss_pkg::hss_kflags_t rxchariscomma;
  hss_pkg::hss_kflags_t rxcharisk;
  logic [1:0]           rxlossofsync;
  hss_pkg::hss_word_t   txdata;
  hss_pkg::hss_kflags_t txcharisk;
  hss_pkg::hss_word_t   tx_data;
  hss_pkg::hss_kflags_t tx_charisk;
  logic                 tx_vld;
  logic                 tx_rdy;
  hss_pkg::hss_word_t   rx_data;
  hss_pkg::hss_kflags_t rx_charisk;
  logic                 rx_vld;

  // Fault mux in front of the receive side
  logic                 fault_en;
  hss_pkg::hss_word_t   fault_data;
  hss_pkg::hss_kflags_t fault_k;

  // Accepted user words, K flags above the data
  logic [35:0]          sb_q[$];
  logic [35:0]          sb_head;
  logic                 saw_phase1;
  integer               seed;
  int                   errors;
  int                   timeouts;
  int                   total;

  always #10 clk = ~clk;

  hss_link #(
    .CLKCOR_INTERVAL (CLKCOR_INTERVAL),
    .NUM_HANDSHAKES  (NUM_HANDSHAKES)
  ) hss_link_i (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .handshake_complete_o (handshake_complete),
    .version_mismatch_o   (version_mismatch),
    .rxdata_i             (rxdata),
    .rxchariscomma_i      (rxchariscomma),
    .rxcharisk_i          (rxcharisk),
    .rxlossofsync_i       (rxlossofsync),
    .txdata_o             (txdata),
    .txcharisk_o          (txcharisk),
    .tx_data_i            (tx_data),
    .tx_charisk_i         (tx_charisk),
    .tx_vld_i             (tx_vld),
    .tx_rdy_o             (tx_rdy),
    .rx_data_o            (rx_data),
    .rx_charisk_o         (rx_charisk),
    .rx_vld_o             (rx_vld)
  );

  //////////////////////////////////////////////////////////////////////
  // Loopback with fault mux
  //////////////////////////////////////////////////////////////////////

  assign rxdata    = fault_en ? fault_data : txdata;
  assign rxcharisk = fault_en ? fault_k    : txcharisk;

  // Comma flag on every K byte that holds K28.5
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      rxchariscomma[b] = rxcharisk[b] && (rxdata[8*b +: 8] == hss_pkg::COMMA_K);
    end
  end

  // Handshake layout: phase in bit 0 of byte 3, version, marker, comma
  function automatic hss_pkg::hss_word_t hs_word(input logic phase, input logic [7:0] ver);
    hs_word = {7'b0000000, phase, ver, hss_pkg::HS_MARKER, hss_pkg::COMMA_K};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_phase1_seen();
    assert (saw_phase1) else begin
      errors++;
      $display("handshake completed without phase 1 words on txdata_o");
    end
  endtask

  // Current level of a condition the sequence waits on
  function automatic logic probe(input string name);
    if (name == "handshake_complete_o") begin
      probe = handshake_complete;
    end else if (name == "version_mismatch_o") begin
      probe = version_mismatch;
    end else begin
      probe = (sb_q.size() == 0);
    end
  endfunction

  task automatic wait_for(input string name, input logic level);
    int n;
    n = 0;
    while (probe(name) !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (probe(name) !== level) begin
      timeouts++;
      $display("timeout: %s did not become %0d within %0d cycles", name, level, WAIT_LIMIT);
    end
  endtask

  // Random words with gaps; a word is held until tx_rdy_o takes it
  task automatic send_words(input int count);
    int   sent;
    int   cycles;
    int   pick;
    logic went;
    sent   = 0;
    cycles = 0;
    went   = 1'b0;
    while (sent < count && cycles < count * 4 + WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (!tx_vld || went) begin
        pick       = $random(seed);
        tx_vld     = (pick[1:0] != 2'b00);
        tx_data    = $random(seed);
        // Byte 0 never K, so every word is a user word
        tx_charisk = {pick[4:2], 1'b0};
      end
      // tx_rdy_o only moves on rising edges, so this is what the next edge sees
      went = tx_vld && tx_rdy;
      if (went) begin
        sb_q.push_back({tx_charisk, tx_data});
        sent++;
      end
    end
    if (sent < count) begin
      timeouts++;
      $display("timeout: only %0d of %0d user words accepted", sent, count);
    end
    @(negedge clk);
    tx_vld = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Lane and receive port monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (txcharisk == 4'b0001 && txdata[15:8] == hss_pkg::HS_MARKER && txdata[24]) begin
      saw_phase1 = 1'b1;
    end
    if (rst_n && rx_vld) begin
      if (sb_q.size() == 0) begin
        errors++;
        $display("rx_vld_o raised with no user word outstanding");
      end else begin
        sb_head = sb_q.pop_front();
        check_value("rx_data_o", rx_data, sb_head[31:0]);
        check_value("rx_charisk_o", rx_charisk, sb_head[35:32]);
      end
    end
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    tx_data      = '0;
    tx_charisk   = '0;
    tx_vld       = 1'b0;
    rxlossofsync = 2'b00;
    fault_en     = 1'b0;
    fault_data   = '0;
    fault_k      = '0;
    saw_phase1   = 1'b0;
    seed         = 45389;
    errors       = 0;
    timeouts     = 0;

    // Reset for 8 cycles, quiet outputs and a phase-0 handshake word
    repeat (8) @(negedge clk);
    check_value("tx_rdy_o", tx_rdy, 1'b0);
    check_value("rx_vld_o", rx_vld, 1'b0);
    check_value("handshake_complete_o", handshake_complete, 1'b0);
    check_value("version_mismatch_o", version_mismatch, 1'b0);
    check_value("txdata_o", txdata, hs_word(1'b0, hss_pkg::PROTOCOL_VERSION));
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("txdata_o", txdata, hs_word(1'b0, hss_pkg::PROTOCOL_VERSION));
      check_value("txcharisk_o", txcharisk, 4'b0001);
    end

    // Loopback handshake, then user traffic
    wait_for("handshake_complete_o", 1'b1);
    check_phase1_seen();
    send_words(200);
    wait_for("scoreboard_empty", 1'b1);

    // Remote speaks another version
    @(negedge clk);
    fault_data = hs_word(1'b0, hss_pkg::PROTOCOL_VERSION ^ 8'h80);
    fault_k    = 4'b0001;
    fault_en   = 1'b1;
    wait_for("version_mismatch_o", 1'b1);
    repeat (30) begin
      @(negedge clk);
      check_value("handshake_complete_o", handshake_complete, 1'b0);
    end
    fault_en = 1'b0;
    wait_for("version_mismatch_o", 1'b0);
    saw_phase1 = 1'b0;
    wait_for("handshake_complete_o", 1'b1);
    check_phase1_seen();

    // Loss of sync takes the link down until released
    rxlossofsync = 2'b10;
    wait_for("handshake_complete_o", 1'b0);
    repeat (10) begin
      @(negedge clk);
      check_value("tx_rdy_o", tx_rdy, 1'b0);
      check_value("handshake_complete_o", handshake_complete, 1'b0);
    end
    rxlossofsync = 2'b00;
    saw_phase1   = 1'b0;
    wait_for("handshake_complete_o", 1'b1);
    check_phase1_seen();
    send_words(60);
    wait_for("scoreboard_empty", 1'b1);

    total = errors + timeouts + hss_link_i.props_i.fail_cnt;
    $display("errors: %0d check, %0d timeout, %0d assertion",
             errors, timeouts, hss_link_i.props_i.fail_cnt);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- flist.f
design/hss_pkg.sv
design/hss_tx_control.sv
design/hss_rx_control.sv
design/hss_link.sv
tests/hss_link_properties.sv
tests/hss_link_tb.sv

//--- Bender.yml
package:
  name: hss_link

sources:
  - design/hss_pkg.sv
  - design/hss_tx_control.sv
  - design/hss_rx_control.sv
  - design/hss_link.sv
  - target: test
    files:
      - tests/hss_link_properties.sv
      - tests/hss_link_tb.sv
